// File: common/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// datapath and address width
`define CPU_DATA_W 32

// register file size
`define CPU_REG_N 32
`define CPU_REG_AW 5

// local data memory depth in 32-bit words
`define CPU_DMEM_WORDS 64

`endif

// File: common/isa_pkg.sv
package isa_pkg;

    // memory access kind carried with each instruction
    typedef enum logic [2:0]
    {
        mem_none       = 3'd0,
        mem_load_word  = 3'd1,
        mem_load_byte  = 3'd2,
        mem_store_word = 3'd3,
        mem_store_byte = 3'd4
    } mem_op_e;

    // where the write-back value comes from
    typedef enum logic
    {
        wb_from_alu = 1'b0,
        wb_from_mem = 1'b1
    } wb_src_e;

endpackage

// File: common/pipe_pkg.sv
`include "cpu_cfg.svh"

package pipe_pkg;

    ////////////////////
    // stage buses
    ////////////////////

    // execute -> memory
    typedef struct packed
    {
        logic [`CPU_DATA_W-1:0]  pc;
        isa_pkg::mem_op_e        mem_op;
        logic [`CPU_DATA_W-1:0]  alu_result;
        logic [`CPU_DATA_W-1:0]  store_data;
        logic                    rf_we;
        logic [`CPU_REG_AW-1:0]  rf_waddr;
    } ex_to_mem_t;

    // memory -> write-back
    typedef struct packed
    {
        logic [`CPU_DATA_W-1:0]  pc;
        logic                    rf_we;
        isa_pkg::wb_src_e        wb_src;
        logic                    load_byte;
        logic [3:0]              byte_en;
        logic [`CPU_DATA_W-1:0]  mem_rdata;
        logic [`CPU_DATA_W-1:0]  alu_result;
        logic [`CPU_REG_AW-1:0]  rf_waddr;
    } mem_to_wb_t;

    ////////////////////
    // write and debug
    ////////////////////

    // register write that also goes out as the forwarding bus
    typedef struct packed
    {
        logic                    we;
        logic [`CPU_REG_AW-1:0]  waddr;
        logic [`CPU_DATA_W-1:0]  wdata;
    } rf_write_t;

    typedef struct packed
    {
        logic [`CPU_DATA_W-1:0]  pc;
        logic [3:0]              rf_wen;
        logic [`CPU_REG_AW-1:0]  rf_wnum;
        logic [`CPU_DATA_W-1:0]  rf_wdata;
    } wb_trace_t;

endpackage

// File: design/mem_stage.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module mem_stage
(
    input  logic                 clk,
    input  logic                 reset,
    input  pipe_pkg::ex_to_mem_t ex_bus,
    input  logic                 ex_valid,
    output logic                 ex_allow_in,
    output pipe_pkg::mem_to_wb_t mem_bus,
    output logic                 mem_valid,
    input  logic                 wb_allow_in
);
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int DMEM_AW = $clog2(`CPU_DMEM_WORDS);

    logic                   stage_valid;
    logic                   ready_go;
    logic                   mem_fire;
    ex_to_mem_t             ex_reg;
    logic [`CPU_DATA_W-1:0] dmem [0:`CPU_DMEM_WORDS-1];
    logic [DMEM_AW-1:0]     word_idx;
    logic [1:0]             lane;
    logic [`CPU_DATA_W-1:0] rdata;
    logic                   is_load;

    ////////////////////
    // pipeline control
    ////////////////////

    assign ready_go    = 1'b1;
    assign ex_allow_in = ~stage_valid | (ready_go & wb_allow_in);
    assign mem_valid   = stage_valid & ready_go;
    // instruction leaves this stage on this edge
    assign mem_fire    = mem_valid & wb_allow_in;

    always_ff @(posedge clk)
    begin
        if (reset)
            stage_valid <= 1'b0;
        else if (ex_allow_in)
            stage_valid <= ex_valid;
    end

    always_ff @(posedge clk)
    begin
        if (ex_valid && ex_allow_in)
            ex_reg <= ex_bus;
    end

    ////////////////////
    // data memory
    ////////////////////

    // word index above the byte offset
    assign word_idx = ex_reg.alu_result[DMEM_AW+1:2];
    assign lane     = ex_reg.alu_result[1:0];
    assign rdata    = dmem[word_idx];

    always_ff @(posedge clk)
    begin
        if (mem_fire && ex_reg.mem_op == mem_store_word)
            dmem[word_idx] <= ex_reg.store_data;
        else if (mem_fire && ex_reg.mem_op == mem_store_byte)
            dmem[word_idx][lane*8 +: 8] <= ex_reg.store_data[7:0];
    end

    ////////////////////
    // bus to write-back
    ////////////////////

    assign is_load = (ex_reg.mem_op == mem_load_word) || (ex_reg.mem_op == mem_load_byte);

    always_comb
    begin
        mem_bus.pc         = ex_reg.pc;
        mem_bus.rf_we      = ex_reg.rf_we;
        mem_bus.wb_src     = is_load ? wb_from_mem : wb_from_alu;
        mem_bus.load_byte  = (ex_reg.mem_op == mem_load_byte);
        mem_bus.byte_en    = 4'b0000;
        mem_bus.mem_rdata  = rdata;
        mem_bus.alu_result = ex_reg.alu_result;
        mem_bus.rf_waddr   = ex_reg.rf_waddr;
        // lane 0 is the low byte
        if (ex_reg.mem_op == mem_load_byte)
            mem_bus.byte_en = 4'b0001 << lane;
    end

    // opcode from execute must decode
    assert property (@(posedge clk) disable iff (reset)
        mem_valid |-> ex_reg.mem_op inside {mem_none, mem_load_word, mem_load_byte,
                                            mem_store_word, mem_store_byte});

endmodule

// File: design/regfile.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module regfile
(
    input  logic                   clk,
    input  logic                   reset,
    input  pipe_pkg::rf_write_t    rf_wr,
    input  logic [`CPU_REG_AW-1:0] raddr_a,
    input  logic [`CPU_REG_AW-1:0] raddr_b,
    output logic [`CPU_DATA_W-1:0] rdata_a,
    output logic [`CPU_DATA_W-1:0] rdata_b
);

    logic [`CPU_DATA_W-1:0] regs [0:`CPU_REG_N-1];

    ////////////////////
    // write port
    ////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < `CPU_REG_N; i++)
                regs[i] <= '0;
        end
        // writes to r0 are dropped
        else if (rf_wr.we && rf_wr.waddr != '0)
        begin
            regs[rf_wr.waddr] <= rf_wr.wdata;
        end
    end

    ////////////////////
    // read ports
    ////////////////////

    // combinational reads with r0 forced to zero
    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

    // r0 never picks up a value from write-back
    assert property (@(posedge clk) disable iff (reset)
        regs[0] == '0);

endmodule

// File: design/wb_stage.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module wb_stage
(
    input  logic                 clk,
    input  logic                 reset,
    input  pipe_pkg::mem_to_wb_t mem_bus,
    input  logic                 mem_valid,
    output logic                 wb_allow_in,
    output pipe_pkg::rf_write_t  rf_wr,
    output pipe_pkg::wb_trace_t  trace
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic                   wb_valid;
    logic                   ready_go;
    mem_to_wb_t             wb_reg;
    logic [`CPU_DATA_W-1:0] load_ext;
    logic [`CPU_DATA_W-1:0] mem_value;
    logic [`CPU_DATA_W-1:0] wdata;

    ////////////////////
    // pipeline control
    ////////////////////

    // register file never stalls, so this stage always drains
    assign ready_go    = 1'b1;
    assign wb_allow_in = ~wb_valid | ready_go;

    always_ff @(posedge clk)
    begin
        if (reset)
            wb_valid <= 1'b0;
        else if (wb_allow_in)
            wb_valid <= mem_valid;
    end

    always_ff @(posedge clk)
    begin
        if (mem_valid && wb_allow_in)
            wb_reg <= mem_bus;
    end

    ////////////////////
    // write data select
    ////////////////////

    // signed byte load from the lane in byte_en
    always_comb
    begin
        case (wb_reg.byte_en)
            4'b0001: load_ext = {{24{wb_reg.mem_rdata[7]}},  wb_reg.mem_rdata[7:0]};
            4'b0010: load_ext = {{24{wb_reg.mem_rdata[15]}}, wb_reg.mem_rdata[15:8]};
            4'b0100: load_ext = {{24{wb_reg.mem_rdata[23]}}, wb_reg.mem_rdata[23:16]};
            4'b1000: load_ext = {{24{wb_reg.mem_rdata[31]}}, wb_reg.mem_rdata[31:24]};
            default: load_ext = '0;
        endcase
    end

    assign mem_value = wb_reg.load_byte ? load_ext : wb_reg.mem_rdata;
    assign wdata     = (wb_reg.wb_src == wb_from_mem) ? mem_value : wb_reg.alu_result;

    ////////////////////
    // write and trace
    ////////////////////

    assign rf_wr.we    = wb_valid & ready_go & wb_reg.rf_we;
    assign rf_wr.waddr = wb_reg.rf_waddr;
    assign rf_wr.wdata = wdata;

    assign trace.pc       = wb_reg.pc;
    assign trace.rf_wen   = {4{rf_wr.we}};
    assign trace.rf_wnum  = wb_reg.rf_waddr;
    assign trace.rf_wdata = wdata;

    // mem stage must hand over exactly one lane for a byte load
    assert property (@(posedge clk) disable iff (reset)
        (wb_valid && wb_reg.load_byte) |-> $onehot(wb_reg.byte_en));

endmodule

// File: design/wb_subsys_top.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module wb_subsys_top
(
    input  logic                   clk,
    input  logic                   reset,
    input  pipe_pkg::ex_to_mem_t   ex_bus,
    input  logic                   ex_valid,
    output logic                   ex_allow_in,
    input  logic [`CPU_REG_AW-1:0] raddr_a,
    input  logic [`CPU_REG_AW-1:0] raddr_b,
    output logic [`CPU_DATA_W-1:0] rdata_a,
    output logic [`CPU_DATA_W-1:0] rdata_b,
    output pipe_pkg::rf_write_t    fwd_bus,
    output pipe_pkg::wb_trace_t    trace
);
    import pipe_pkg::*;

    mem_to_wb_t mem_bus;
    logic       mem_valid;
    logic       wb_allow_in;
    rf_write_t  rf_wr;

    mem_stage u_mem_stage
    (
        .clk         (clk),
        .reset       (reset),
        .ex_bus      (ex_bus),
        .ex_valid    (ex_valid),
        .ex_allow_in (ex_allow_in),
        .mem_bus     (mem_bus),
        .mem_valid   (mem_valid),
        .wb_allow_in (wb_allow_in)
    );

    wb_stage u_wb_stage
    (
        .clk         (clk),
        .reset       (reset),
        .mem_bus     (mem_bus),
        .mem_valid   (mem_valid),
        .wb_allow_in (wb_allow_in),
        .rf_wr       (rf_wr),
        .trace       (trace)
    );

    regfile u_regfile
    (
        .clk     (clk),
        .reset   (reset),
        .rf_wr   (rf_wr),
        .raddr_a (raddr_a),
        .raddr_b (raddr_b),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b)
    );

    // same write exported for a later bypass network
    assign fwd_bus = rf_wr;

endmodule

// File: dv/tb_wb_subsys.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module tb_wb_subsys;
    import isa_pkg::*;
    import pipe_pkg::*;

    // 69 instructions issued over the five tests
    localparam int NUM_INSTR      = 69;
    localparam int TIMEOUT_CYCLES = 2 * NUM_INSTR + 100;

    logic                   clk = 1'b0;
    logic                   reset;
    ex_to_mem_t             ex_bus;
    logic                   ex_valid;
    logic                   ex_allow_in;
    logic [`CPU_REG_AW-1:0] raddr_a;
    logic [`CPU_REG_AW-1:0] raddr_b;
    logic [`CPU_DATA_W-1:0] rdata_a;
    logic [`CPU_DATA_W-1:0] rdata_b;
    rf_write_t              fwd_bus;
    wb_trace_t              trace;

    int                     cyc = 0;
    int                     errors = 0;
    int                     checks = 0;
    logic [15:0]            lfsr = 16'd44;
    logic [`CPU_DATA_W-1:0] pc_next = 32'h0000_1000;
    logic [`CPU_DATA_W-1:0] ref_regs [0:`CPU_REG_N-1];
    logic [`CPU_DATA_W-1:0] ref_mem [0:`CPU_DMEM_WORDS-1];
    logic [5:0]             saved_idx [0:5];
    wb_trace_t              exp_trace [$];
    int                     exp_due [$];

    wb_subsys_top uut
    (
        .clk         (clk),
        .reset       (reset),
        .ex_bus      (ex_bus),
        .ex_valid    (ex_valid),
        .ex_allow_in (ex_allow_in),
        .raddr_a     (raddr_a),
        .raddr_b     (raddr_b),
        .rdata_a     (rdata_a),
        .rdata_b     (rdata_b),
        .fwd_bus     (fwd_bus),
        .trace       (trace)
    );

    always #10 clk = ~clk;

    always @(posedge clk)
    begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT_CYCLES)
        begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR @%0t: %s", $time, msg);
    endtask

    // 16-bit Fibonacci LFSR with polynomial x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] make_addr(input logic [5:0] idx, input logic [1:0] lane);
        return {24'd0, idx, lane};
    endfunction

    ////////////////////
    // drive and model
    ////////////////////

    task automatic issue(input mem_op_e op, input logic [31:0] alu, input logic [31:0] sd,
                         input logic we, input logic [4:0] waddr);
        ex_to_mem_t b;
        wb_trace_t  e;
        logic [5:0] idx;
        logic [1:0] lane;
        logic [7:0] byte_val;
        idx        = alu[7:2];
        lane       = alu[1:0];
        e.rf_wdata = alu;
        case (op)
            mem_store_word: ref_mem[idx] = sd;
            mem_store_byte: ref_mem[idx][lane*8 +: 8] = sd[7:0];
            mem_load_word:  e.rf_wdata = ref_mem[idx];
            mem_load_byte:
            begin
                byte_val   = ref_mem[idx][lane*8 +: 8];
                e.rf_wdata = {{24{byte_val[7]}}, byte_val};
            end
            default: ;
        endcase
        e.pc      = pc_next;
        e.rf_wen  = we ? 4'hf : 4'h0;
        e.rf_wnum = waddr;
        if (we && waddr != 5'd0)
            ref_regs[waddr] = e.rf_wdata;
        b.pc         = pc_next;
        b.mem_op     = op;
        b.alu_result = alu;
        b.store_data = sd;
        b.rf_we      = we;
        b.rf_waddr   = waddr;
        @(posedge clk);
        ex_bus   <= b;
        ex_valid <= 1'b1;
        // accepted on the next edge and latched by write-back one edge later
        exp_trace.push_back(e);
        exp_due.push_back(cyc + 3);
        pc_next = pc_next + 32'd4;
    endtask

    task automatic drain();
        @(posedge clk);
        ex_valid <= 1'b0;
        while (exp_due.size() != 0)
            @(posedge clk);
        @(posedge clk);
    endtask

    task automatic check_trace(input wb_trace_t e);
        checks++;
        if (trace.pc !== e.pc || trace.rf_wen !== e.rf_wen || trace.rf_wnum !== e.rf_wnum
            || (e.rf_wen != 4'h0 && trace.rf_wdata !== e.rf_wdata))
            report_error($sformatf("trace pc %h wen %h r%0d %h, expected pc %h wen %h r%0d %h",
                trace.pc, trace.rf_wen, trace.rf_wnum, trace.rf_wdata,
                e.pc, e.rf_wen, e.rf_wnum, e.rf_wdata));
        if (fwd_bus.we !== e.rf_wen[0] || fwd_bus.waddr !== e.rf_wnum
            || (e.rf_wen != 4'h0 && fwd_bus.wdata !== e.rf_wdata))
            report_error($sformatf("fwd_bus we %b r%0d %h, expected we %b r%0d %h",
                fwd_bus.we, fwd_bus.waddr, fwd_bus.wdata,
                e.rf_wen[0], e.rf_wnum, e.rf_wdata));
    endtask

    task automatic check_reg(input logic [4:0] r);
        @(posedge clk);
        raddr_a <= r;
        raddr_b <= r;
        @(negedge clk);
        checks++;
        if (rdata_a !== ref_regs[r] || rdata_b !== ref_regs[r])
            report_error($sformatf("r%0d reads %h / %h, expected %h",
                r, rdata_a, rdata_b, ref_regs[r]));
    endtask

    // trace and fwd_bus sampled mid-cycle
    always @(negedge clk)
    begin
        if (!reset)
        begin
            checks++;
            if (ex_allow_in !== 1'b1)
                report_error("ex_allow_in dropped");
            if (exp_due.size() != 0 && exp_due[0] == cyc)
            begin
                check_trace(exp_trace.pop_front());
                void'(exp_due.pop_front());
            end
            else if (trace.rf_wen !== 4'h0 || fwd_bus.we !== 1'b0)
                report_error("register write with no instruction due");
        end
    end

    ////////////////////
    // tests
    ////////////////////

    task automatic test_alu_writeback();
        for (int r = 1; r <= 8; r++)
            issue(mem_none, rand_bits(32), 32'h0, 1'b1, 5'(r));
        drain();
        for (int r = 1; r <= 8; r++)
            check_reg(5'(r));
    endtask

    task automatic test_word_store_load();
        for (int i = 0; i < 6; i++)
        begin
            saved_idx[i] = 6'(rand_bits(6));
            issue(mem_store_word, make_addr(saved_idx[i], 2'd0), rand_bits(32), 1'b0, 5'd0);
        end
        for (int i = 0; i < 6; i++)
            issue(mem_load_word, make_addr(saved_idx[i], 2'd0), 32'h0, 1'b1, 5'(9 + i));
        drain();
        for (int i = 0; i < 6; i++)
            check_reg(5'(9 + i));
    endtask

    task automatic test_byte_lanes();
        logic [5:0]  idx;
        logic [31:0] sd;
        idx = 6'(rand_bits(6));
        issue(mem_store_word, make_addr(idx, 2'd0), rand_bits(32), 1'b0, 5'd0);
        for (int l = 0; l < 4; l++)
        begin
            for (int k = 0; k < 2; k++)
            begin
                sd    = rand_bits(32);
                // one negative and one positive byte per lane
                sd[7] = (k == 0);
                issue(mem_store_byte, make_addr(idx, l[1:0]), sd, 1'b0, 5'd0);
                issue(mem_load_byte, make_addr(idx, l[1:0]), 32'h0, 1'b1, 5'd20);
                issue(mem_load_word, make_addr(idx, 2'd0), 32'h0, 1'b1, 5'd21);
            end
        end
        drain();
        check_reg(5'd20);
        check_reg(5'd21);
    endtask

    task automatic test_reg_zero();
        issue(mem_none, rand_bits(32), 32'h0, 1'b1, 5'd0);
        issue(mem_none, rand_bits(32), 32'h0, 1'b0, 5'd3);
        issue(mem_none, rand_bits(32), 32'h0, 1'b0, 5'd5);
        issue(mem_load_word, make_addr(saved_idx[0], 2'd0), 32'h0, 1'b0, 5'd7);
        drain();
        check_reg(5'd0);
        check_reg(5'd3);
        check_reg(5'd5);
        check_reg(5'd7);
    endtask

    task automatic test_stream();
        logic [5:0] idx;
        logic [1:0] lane;
        idx  = 6'd0;
        lane = 2'd0;
        for (int i = 0; i < 20; i++)
        begin
            case (i % 5)
                0: issue(mem_none, rand_bits(32), 32'h0, 1'b1, 5'(rand_bits(5)));
                1:
                begin
                    idx = 6'(rand_bits(6));
                    issue(mem_store_word, make_addr(idx, 2'd0), rand_bits(32), 1'b0, 5'd0);
                end
                // load right behind the store to the same word
                2: issue(mem_load_word, make_addr(idx, 2'd0), 32'h0, 1'b1, 5'(rand_bits(5)));
                3:
                begin
                    lane = 2'(rand_bits(2));
                    issue(mem_store_byte, make_addr(idx, lane), rand_bits(32), 1'b0, 5'd0);
                end
                default: issue(mem_load_byte, make_addr(idx, lane), 32'h0, 1'b1,
                               5'(rand_bits(5)));
            endcase
        end
        drain();
    endtask

    initial
    begin
        reset    = 1'b1;
        ex_valid = 1'b0;
        ex_bus   = '0;
        raddr_a  = 5'd0;
        raddr_b  = 5'd0;
        for (int i = 0; i < `CPU_REG_N; i++)
            ref_regs[i] = '0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        test_alu_writeback();
        test_word_store_load();
        test_byte_lanes();
        test_reg_zero();
        test_stream();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+common
common/isa_pkg.sv
common/pipe_pkg.sv
design/mem_stage.sv
design/wb_stage.sv
design/regfile.sv
design/wb_subsys_top.sv
dv/tb_wb_subsys.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_wb_subsys -f filelist.f -Mdir obj_dir &&
./obj_dir/Vtb_wb_subsys | tee /dev/stderr | grep -x "TEST PASS" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
